//--- common/vector_pkg.sv
`default_nettype none

package vector_pkg;

    // ==========================================================
    // Half precision word layout
    // ==========================================================

    // Sign, biased exponent, stored fraction (hidden bit implied)
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } fp16_t;

    // ==========================================================
    // Format constants
    // ==========================================================

    // Exponent bias of the binary16 format
    localparam int FP16_BIAS = 15;

    // Largest biased exponent of a finite value
    // Exponent 31 encodes inf/NaN, which this unit never produces
    localparam int FP16_MAX_EXP = 30;

    // ==========================================================
    // Polynomial coefficients
    // ==========================================================

    // +1.0
    localparam fp16_t FP16_ONE = 16'h3C00;

    // Nearest fp16 below 1/6, coefficient of the cubic term
    localparam fp16_t FP16_ONE_SIXTH = 16'h3155;

endpackage

`default_nettype wire

//--- vexp/fp16_add.sv
`default_nettype none

module fp16_add (
    input  vector_pkg::fp16_t a,
    input  vector_pkg::fp16_t b,
    output vector_pkg::fp16_t sum
);

    // Working significand: hidden bit, 10 fraction bits, 3 guard bits
    // Raw result carries one more bit on top for the carry out
    vector_pkg::fp16_t op_hi;
    vector_pkg::fp16_t op_lo;
    logic [14:0]       mag_a;
    logic [14:0]       mag_b;
    logic [13:0]       m_hi;
    logic [13:0]       m_lo;
    logic [13:0]       m_lo_al;
    logic [4:0]        shift;
    logic [14:0]       raw;
    logic [3:0]        lz;
    logic [14:0]       norm;
    logic signed [6:0] exp_n;

    // Number of zeros above the leading one, 15 when v is zero
    function automatic logic [3:0] lead_zeros(input logic [14:0] v);
        logic [3:0] n;
        logic       found;
        n = 4'd0;
        found = 1'b0;
        for (int i = 14; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 4'd1;
                end
            end
        end
        return n;
    endfunction

    always_comb begin
        // Subnormals count as zero magnitude
        mag_a = (a.exp == 5'd0) ? 15'd0 : {a.exp, a.frac};
        mag_b = (b.exp == 5'd0) ? 15'd0 : {b.exp, b.frac};

        // Larger magnitude first so the difference never goes negative
        if (mag_a >= mag_b) begin
            op_hi = a;
            op_lo = b;
        end else begin
            op_hi = b;
            op_lo = a;
        end

        m_hi = (op_hi.exp == 5'd0) ? 14'd0 : {1'b1, op_hi.frac, 3'b000};
        m_lo = (op_lo.exp == 5'd0) ? 14'd0 : {1'b1, op_lo.frac, 3'b000};

        // Alignment, bits shifted past the guard bits are lost
        shift = op_hi.exp - op_lo.exp;
        m_lo_al = m_lo >> shift;

        if (op_hi.sign == op_lo.sign) begin
            raw = {1'b0, m_hi} + {1'b0, m_lo_al};
        end else begin
            raw = {1'b0, m_hi} - {1'b0, m_lo_al};
        end

        // Leading one moves to bit 14, exponent tracks the shift
        lz = lead_zeros(raw);
        norm = raw << lz;
        exp_n = 7'(int'(op_hi.exp) + 1 - int'(lz));

        if (raw == 15'd0) begin
            // Exact cancellation is +0 unless both inputs are negative
            sum.sign = a.sign & b.sign;
            sum.exp  = 5'd0;
            sum.frac = 10'd0;
        end else if (exp_n <= 0) begin
            // Below the normal range
            sum.sign = op_hi.sign;
            sum.exp  = 5'd0;
            sum.frac = 10'd0;
        end else if (exp_n > vector_pkg::FP16_MAX_EXP) begin
            // Saturate to the largest finite value
            sum.sign = op_hi.sign;
            sum.exp  = 5'(vector_pkg::FP16_MAX_EXP);
            sum.frac = '1;
        end else begin
            // Truncate, the guard bits are dropped here
            sum.sign = op_hi.sign;
            sum.exp  = exp_n[4:0];
            sum.frac = norm[13:4];
        end
    end

endmodule

`default_nettype wire

//--- vexp/mul_fp16.sv
`default_nettype none

module mul_fp16 #(
    parameter int MUL_LATENCY = 2
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              start,
    input  vector_pkg::fp16_t a,
    input  vector_pkg::fp16_t b,
    output vector_pkg::fp16_t result,
    output logic              done
);

    // Unnormalised product as it moves down the pipe
    typedef struct packed {
        logic              sign;
        logic              zero;
        logic signed [6:0] exp;
        logic [21:0]       prod;
    } raw_t;

    raw_t                   first;
    raw_t                   last;
    raw_t                   pipe_q [MUL_LATENCY];
    logic [MUL_LATENCY-1:0] vld_q;
    logic signed [6:0]      exp_n;
    logic [9:0]             frac_n;

    // ==========================================================
    // First stage: significand product and exponent sum
    // ==========================================================
    always_comb begin
        first.sign = a.sign ^ b.sign;
        // Zero and subnormal operands both flush
        first.zero = (a.exp == 5'd0) || (b.exp == 5'd0);
        first.exp  = 7'(int'(a.exp) + int'(b.exp) - vector_pkg::FP16_BIAS);
        first.prod = {1'b1, a.frac} * {1'b1, b.frac};
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge CLK) begin
        pipe_q[0] <= first;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            pipe_q[i] <= pipe_q[i-1];
        end
    end

    assign done = vld_q[MUL_LATENCY-1];

    // ==========================================================
    // Output: normalise and truncate
    // ==========================================================
    always_comb begin
        last = pipe_q[MUL_LATENCY-1];

        // Product of two values in [1,2) lies in [1,4)
        exp_n  = last.exp + (last.prod[21] ? 7'sd1 : 7'sd0);
        frac_n = last.prod[21] ? last.prod[20:11] : last.prod[19:10];

        result.sign = last.sign;
        if (last.zero || exp_n <= 0) begin
            result.exp  = 5'd0;
            result.frac = 10'd0;
        end else if (exp_n > vector_pkg::FP16_MAX_EXP) begin
            result.exp  = 5'(vector_pkg::FP16_MAX_EXP);
            result.frac = '1;
        end else begin
            result.exp  = exp_n[4:0];
            result.frac = frac_n;
        end
    end

    // A valid product never carries unknown bits from the operands
    assert property (@(posedge CLK) disable iff (!nRST) done |-> !$isunknown(result))
        else $error("mul_fp16: unknown bits in result while done is high");

endmodule

`default_nettype wire

//--- vexp/vexp.sv
`default_nettype none

module vexp #(
    parameter int MUL_LATENCY = 2
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              enable,
    input  vector_pkg::fp16_t x,
    output vector_pkg::fp16_t y,
    output logic              out_valid
);

    // Running sum, input word and scale factor travel together
    typedef struct packed {
        vector_pkg::fp16_t acc;
        vector_pkg::fp16_t x;
        vector_pkg::fp16_t scale;
    } carry_t;

    // Multiplier issue side, one slot per stage
    logic [3:0]        mul_start;
    logic [3:0]        mul_done;
    vector_pkg::fp16_t mul_a   [4];
    vector_pkg::fp16_t mul_b   [4];
    vector_pkg::fp16_t mul_res [4];

    // Carry copies that keep pace with the multipliers of stages 1..3
    carry_t iss_q [3];
    carry_t dly_q [3][MUL_LATENCY];

    // Stage outputs
    logic [2:0]        st_v;
    carry_t            st_q [3];
    vector_pkg::fp16_t st_p [2];

    vector_pkg::fp16_t scale;
    vector_pkg::fp16_t r2_half;
    vector_pkg::fp16_t sum1;
    vector_pkg::fp16_t sum2;
    vector_pkg::fp16_t sum3;

    // Power of two from sign and exponent, zero input maps to +1.0
    always_comb begin
        scale = x;
        scale.frac = 10'd0;
        if (x.exp == 5'd0 && x.frac == 10'd0) begin
            scale = vector_pkg::FP16_ONE;
        end
    end

    // Halving by exponent decrement; a zero square stays zero
    always_comb begin
        r2_half = st_p[0];
        if (st_p[0].exp != 5'd0) begin
            r2_half.exp = st_p[0].exp - 5'd1;
        end
    end

    fp16_add u_add1 (.a(vector_pkg::FP16_ONE), .b(x), .sum(sum1));
    fp16_add u_add2 (.a(st_q[0].acc), .b(r2_half), .sum(sum2));
    // r^3/6 is added as it leaves the third multiplier
    fp16_add u_add3 (.a(dly_q[2][MUL_LATENCY-1].acc), .b(mul_res[2]), .sum(sum3));

    for (genvar k = 0; k < 4; k++) begin : g_mul
        mul_fp16 #(
            .MUL_LATENCY(MUL_LATENCY)
        ) u_mul (
            .CLK    (CLK),
            .nRST   (nRST),
            .start  (mul_start[k]),
            .a      (mul_a[k]),
            .b      (mul_b[k]),
            .result (mul_res[k]),
            .done   (mul_done[k])
        );

        // Stage alignment relies on this fixed depth
        assert property (@(posedge CLK) disable iff (!nRST)
            mul_done[k] == $past(mul_start[k], MUL_LATENCY))
            else $error("vexp: multiplier %0d done out of step with start", k);
    end

    // ==========================================================
    // Valid pipeline
    // ==========================================================
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mul_start <= '0;
            st_v      <= '0;
            out_valid <= 1'b0;
            y         <= '0;
        end else begin
            mul_start <= {st_v, enable};
            st_v      <= mul_done[2:0];
            out_valid <= mul_done[3];
            if (mul_done[3]) begin
                y <= mul_res[3];
            end
        end
    end

    // ==========================================================
    // Operand issue
    // ==========================================================
    always_ff @(posedge CLK) begin
        // Stage 1: 1+r and r*r
        if (enable) begin
            mul_a[0] <= x;
            mul_b[0] <= x;
            iss_q[0] <= '{acc: sum1, x: x, scale: scale};
        end
        // Stage 2: add r^2/2, r^2*r
        if (st_v[0]) begin
            mul_a[1] <= st_p[0];
            mul_b[1] <= st_q[0].x;
            iss_q[1] <= '{acc: sum2, x: st_q[0].x, scale: st_q[0].scale};
        end
        // Stage 3: r^3 times 1/6
        if (st_v[1]) begin
            mul_a[2] <= st_p[1];
            mul_b[2] <= vector_pkg::FP16_ONE_SIXTH;
            iss_q[2] <= st_q[1];
        end
        // Stage 4: polynomial times scale
        if (st_v[2]) begin
            mul_a[3] <= st_q[2].acc;
            mul_b[3] <= st_q[2].scale;
        end
    end

    // Free-running shift, the tail lines up with done
    always_ff @(posedge CLK) begin
        for (int k = 0; k < 3; k++) begin
            dly_q[k][0] <= iss_q[k];
            for (int i = 1; i < MUL_LATENCY; i++) begin
                dly_q[k][i] <= dly_q[k][i-1];
            end
        end
    end

    // Capture on done
    always_ff @(posedge CLK) begin
        for (int k = 0; k < 2; k++) begin
            if (mul_done[k]) begin
                st_q[k] <= dly_q[k][MUL_LATENCY-1];
                st_p[k] <= mul_res[k];
            end
        end
        if (mul_done[2]) begin
            st_q[2] <= '{acc:   sum3,
                         x:     dly_q[2][MUL_LATENCY-1].x,
                         scale: dly_q[2][MUL_LATENCY-1].scale};
        end
    end

endmodule

`default_nettype wire

//--- verilog/vexp_unit.sv
`default_nettype none

module vexp_unit #(
    parameter int LANES       = 4,
    parameter int MUL_LATENCY = 2
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          enable,
    input  vector_pkg::fp16_t [LANES-1:0] x,
    output vector_pkg::fp16_t [LANES-1:0] y,
    output logic                          out_valid
);

    // Lanes run in lockstep, lane 0 speaks for all of them
    logic [LANES-1:0] lane_valid;

    // ==========================================================
    // Lane array
    // ==========================================================
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        vexp #(
            .MUL_LATENCY(MUL_LATENCY)
        ) u_vexp (
            .CLK       (CLK),
            .nRST      (nRST),
            .enable    (enable),
            .x         (x[i]),
            .y         (y[i]),
            .out_valid (lane_valid[i])
        );
    end

    assign out_valid = lane_valid[0];

endmodule

`default_nettype wire

//--- bench/vexp_unit_tb.sv
`default_nettype none

module vexp_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES       = 4;
    localparam int MUL_LATENCY = 2;
    localparam int LATENCY     = 4 * (MUL_LATENCY + 2);
    localparam int NUM_CASES   = 20;
    localparam int COLS        = 2 * LANES;
    localparam int WAIT_LIMIT  = 200;
    localparam int HALF_PERIOD = 10;

    typedef vector_pkg::fp16_t [LANES-1:0] lanes_t;

    logic   CLK;
    logic   nRST;
    logic   enable;
    lanes_t x;
    lanes_t y;
    logic   out_valid;

    // Inputs then expected outputs in rows of COLS words per case
    logic [15:0] case_mem [NUM_CASES * COLS];

    lanes_t expect_q [$];
    int     issue_q [$];
    lanes_t last_y;
    logic   monitor_on;
    int     cycle;

    vexp_unit #(
        .LANES       (LANES),
        .MUL_LATENCY (MUL_LATENCY)
    ) uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .enable    (enable),
        .x         (x),
        .y         (y),
        .out_valid (out_valid)
    );

    always #HALF_PERIOD CLK = ~CLK;

    // ==========================================================
    // Helpers
    // ==========================================================
    task automatic fail_run(input string reason);
        $display("FAIL: see errors above");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %0h, got %0h", name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    function automatic lanes_t case_x(input int k);
        lanes_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = case_mem[k * COLS + i];
        end
        return v;
    endfunction

    function automatic lanes_t case_y(input int k);
        lanes_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = case_mem[k * COLS + LANES + i];
        end
        return v;
    endfunction

    task automatic check_idle_outputs();
        check_value("out_valid", 32'd0, {31'd0, out_valid});
        for (int i = 0; i < LANES; i++) begin
            check_value($sformatf("y[%0d]", i), 32'd0, {16'd0, y[i]});
        end
    endtask

    // Enable stays high until the next issue or go_idle
    task automatic issue(input lanes_t xv, input lanes_t yv);
        @(posedge CLK);
        enable <= 1'b1;
        x      <= xv;
        expect_q.push_back(yv);
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            enable <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        int count;
        count = 0;
        while (expect_q.size() != 0 && count < WAIT_LIMIT) begin
            @(negedge CLK);
            count++;
        end
        if (expect_q.size() != 0) begin
            $display("timed out waiting for out_valid");
            fail_run("timeout");
        end
    endtask

    task automatic run_zero_inputs();
        lanes_t xv;
        lanes_t yv;
        // poly(0) is 1 and the scale of a zero input is +1.0
        xv = '0;
        for (int i = 0; i < LANES; i++) begin
            yv[i] = vector_pkg::FP16_ONE;
        end
        issue(xv, yv);
        go_idle(1);
        wait_drained();
        // Zeros on even lanes next to live data on odd lanes
        xv = case_x(9);
        yv = case_y(9);
        for (int i = 0; i < LANES; i += 2) begin
            xv[i] = '0;
            yv[i] = vector_pkg::FP16_ONE;
        end
        issue(xv, yv);
        go_idle(1);
        wait_drained();
    endtask

    // ==========================================================
    // Output monitor sampling mid-cycle
    // ==========================================================
    always @(negedge CLK) begin
        lanes_t want;
        int     issued_at;
        cycle = cycle + 1;
        if (monitor_on) begin
            if (enable) begin
                issue_q.push_back(cycle);
            end
            if (out_valid) begin
                if (expect_q.size() == 0 || issue_q.size() == 0) begin
                    $display("out_valid arrived with no operation in flight");
                    fail_run("unexpected out_valid");
                end else begin
                    want = expect_q.pop_front();
                    issued_at = issue_q.pop_front();
                    // Result shows LATENCY edges after the edge that drove enable
                    check_value("out_valid cycle", issued_at + LATENCY, cycle);
                    for (int i = 0; i < LANES; i++) begin
                        check_value($sformatf("y[%0d]", i), {16'd0, want[i]}, {16'd0, y[i]});
                    end
                    last_y = y;
                end
            end else begin
                for (int i = 0; i < LANES; i++) begin
                    check_value($sformatf("y[%0d] hold", i), {16'd0, last_y[i]},
                                {16'd0, y[i]});
                end
            end
        end
    end

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        CLK          = 1'b0;
        nRST         = 1'b0;
        enable       = 1'b0;
        x            = '0;
        last_y       = '0;
        monitor_on   = 1'b0;
        cycle        = 0;
        void'($urandom(82514));
        $readmemh("bench/vexp_cases.txt", case_mem);

        // Reset state and the first cycle out of reset
        repeat (4) begin
            @(negedge CLK);
            check_idle_outputs();
        end
        @(posedge CLK);
        nRST <= 1'b1;
        monitor_on = 1'b1;
        @(negedge CLK);
        check_idle_outputs();

        // One operation at a time
        for (int k = 0; k < NUM_CASES; k++) begin
            issue(case_x(k), case_y(k));
            go_idle(1);
            wait_drained();
        end

        run_zero_inputs();

        // One issue per cycle back to back
        for (int k = 0; k < NUM_CASES; k++) begin
            issue(case_x(k), case_y(k));
        end
        go_idle(1);
        wait_drained();

        // Random idle gaps between issues
        for (int k = 0; k < NUM_CASES; k++) begin
            issue(case_x(k), case_y(k));
            go_idle($urandom % 6);
        end
        go_idle(1);
        wait_drained();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/vexp_cases.txt
// x0 x1 x2 x3 : fp16 lane inputs, lane 0 first
// y0 y1 y2 y3 : expected fp16 lane outputs, same lane order
3C00 3C00 3C00 3C00 4155 4155 4155 4155
3800 3800 3800 3800 3A95 3A95 3A95 3A95
BC00 BC00 BC00 BC00 B555 B555 B555 B555
4000 4000 4000 4000 4A55 4A55 4A55 4A55
B800 B800 B800 B800 B4D5 B4D5 B4D5 B4D5
3400 3400 3400 3400 3522 3522 3522 3522
3E00 3E00 3E00 3E00 442F 442F 442F 442F
C000 C000 C000 C000 3954 3954 3954 3954
4200 4200 4200 4200 4E7F 4E7F 4E7F 4E7F
3C00 3800 BC00 4000 4155 3A95 B555 4A55
B800 3400 3E00 C000 B4D5 3522 442F 3954
4200 3C00 3800 BC00 4E7F 4155 3A95 B555
4000 B800 3400 3E00 4A55 B4D5 3522 442F
C000 4200 3C00 3800 3954 4E7F 4155 3A95
BC00 4000 B800 3400 B555 4A55 B4D5 3522
3E00 C000 4200 3C00 442F 3954 4E7F 4155
3800 4000 3400 C000 3A95 4A55 3522 3954
4200 3E00 B800 BC00 4E7F 442F B4D5 B555
3400 3C00 C000 3800 3522 4155 3954 3A95
B800 4200 4000 3E00 B4D5 4E7F 4A55 442F

//--- filelist.f
common/vector_pkg.sv
vexp/fp16_add.sv
vexp/mul_fp16.sv
vexp/vexp.sv
verilog/vexp_unit.sv
bench/vexp_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vexp_unit testbench with Verilator.
# The exit status is nonzero if the build fails or the simulation reports failure.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module vexp_unit_tb \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vvexp_unit_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
